//--- rtl/exu_config.svh
// ----------------------------------------------------------
// Width and size settings for the RV64I execute subsystem.
// Include wherever data width or register count is needed.
// ----------------------------------------------------------
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Integer data path width.
`define EXU_XLEN 64

// Architectural registers, x0 included.
`define EXU_NREGS 32

`endif

//--- rtl/exuPkg.sv
// ----------------------------------------------------------
// Shared types for the execute subsystem: ALU operation codes
// and the payloads carried by the issue and writeback stages.
// ----------------------------------------------------------
`include "exu_config.svh"

package exuPkg;

    // ALU operation selected by the decoder.
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        PASSB    // LUI, b goes straight through.
    } aluOp_e;

    typedef struct packed {
        aluOp_e op;
        logic   useImm;  // b from immediate.
        logic   word;    // 32-bit form, result sign-extended.
    } aluCtrl_t;

    typedef struct packed {
        aluCtrl_t              ctrl;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [`EXU_XLEN-1:0]  imm;
    } issue_t;

    typedef struct packed {
        logic [4:0]            rd;
        logic [`EXU_XLEN-1:0]  data;
    } wbReq_t;

endpackage

//--- rtl/aluDecode.sv
// ----------------------------------------------------------
// Instruction decoder. Maps an RV64I integer instruction to
// ALU control, register indices and immediate; flags the rest.
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "exu_config.svh"

module aluDecode import exuPkg::*; (
    input  logic [31:0] inst,
    output issue_t      dec,
    output logic        illegal
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP32   = 7'b0111011;
    localparam logic [6:0] OPC_IMM32  = 7'b0011011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 zeroF7, altF7, altF3;
    logic                 zeroF6, altF6;
    logic [`EXU_XLEN-1:0] iImm;
    aluOp_e               f3Op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign zeroF7 = (funct7 == 7'b0000000);
    assign altF7  = (funct7 == 7'b0100000);
    assign altF3  = (funct3 == 3'b000) || (funct3 == 3'b101);  // Only ADD/SRL have alternates.
    assign zeroF6 = (inst[31:26] == 6'b000000);
    assign altF6  = (inst[31:26] == 6'b010000);
    assign iImm   = {{(`EXU_XLEN-12){inst[31]}}, inst[31:20]};

    // Base op from funct3; bit 30 picks SRA.
    always_comb begin
        case (funct3)
            3'b000:  f3Op = ADD;
            3'b001:  f3Op = SLL;
            3'b010:  f3Op = SLT;
            3'b011:  f3Op = SLTU;
            3'b100:  f3Op = XOR;
            3'b101:  f3Op = inst[30] ? SRA : SRL;
            3'b110:  f3Op = OR;
            default: f3Op = AND;
        endcase
    end

    always_comb begin
        dec     = '0;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];
        illegal = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP32: begin
                dec.ctrl.op   = (funct3 == 3'b000 && inst[30]) ? SUB : f3Op;
                dec.ctrl.word = (opcode == OPC_OP32);
                illegal = !(zeroF7 || (altF7 && altF3)) ||
                          (opcode == OPC_OP32 && !(altF3 || funct3 == 3'b001));
            end
            OPC_IMM: begin
                dec.ctrl.op     = f3Op;
                dec.ctrl.useImm = 1'b1;
                dec.imm         = iImm;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    dec.imm = {{(`EXU_XLEN-6){1'b0}}, inst[25:20]};  // 6-bit shamt.
                    illegal = !(zeroF6 || (funct3 == 3'b101 && altF6));
                end
            end
            OPC_IMM32: begin
                dec.ctrl.op     = f3Op;
                dec.ctrl.useImm = 1'b1;
                dec.ctrl.word   = 1'b1;
                dec.imm         = iImm;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    dec.imm = {{(`EXU_XLEN-5){1'b0}}, inst[24:20]};
                    illegal = !(zeroF7 || (funct3 == 3'b101 && altF7));
                end else begin
                    illegal = (funct3 != 3'b000);
                end
            end
            OPC_LUI: begin
                dec.ctrl.op     = PASSB;
                dec.ctrl.useImm = 1'b1;
                dec.rs1         = 5'd0;
                dec.imm         = {{(`EXU_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

//--- rtl/regFile.sv
// ----------------------------------------------------------
// Integer register file, two read ports and one write port.
// Reads are combinational and see a same-cycle write.
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "exu_config.svh"

module regFile import exuPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    output logic [`EXU_XLEN-1:0] rdata1,
    output logic [`EXU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  wbReq_t               wr
);

    logic [`EXU_XLEN-1:0] regs [`EXU_NREGS];
    logic                 wrEn;

    assign wrEn = we && (wr.rd != 5'd0);  // x0 is never written.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through for a producer in the writeback stage.
    assign rdata1 = (rs1 == 5'd0) ? '0 :
                    (wrEn && wr.rd == rs1) ? wr.data : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 :
                    (wrEn && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

//--- rtl/alu.sv
// ----------------------------------------------------------
// 64-bit integer ALU. One shared adder serves add, sub and
// both compares; word forms sign-extend the low 32 bits.
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "exu_config.svh"

module alu import exuPkg::*; (
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    input  aluCtrl_t             ctrl,
    output logic [`EXU_XLEN-1:0] result
);

    localparam int MSB = `EXU_XLEN - 1;

    logic             sub;
    logic [MSB:0]     bInv;
    logic [MSB:0]     sum;
    logic             carry;
    logic             overflow;
    logic             lessSigned, lessUnsigned;
    logic [5:0]       shamt;
    logic [31:0]      srlWord, sraWord;
    logic [MSB:0]     sraFull;
    logic [MSB:0]     raw;

    assign sub  = (ctrl.op == SUB) || (ctrl.op == SLT) || (ctrl.op == SLTU);
    assign bInv = b ^ {`EXU_XLEN{sub}};
    assign {carry, sum} = {1'b0, a} + {1'b0, bInv} + {{`EXU_XLEN{1'b0}}, sub};

    // Operands of equal sign giving a result of the other sign.
    assign overflow     = (a[MSB] == bInv[MSB]) && (sum[MSB] != a[MSB]);
    assign lessSigned   = sum[MSB] ^ overflow;
    assign lessUnsigned = ~carry;     // No carry out means a borrow.

    assign shamt   = ctrl.word ? {1'b0, b[4:0]} : b[5:0];
    assign srlWord = a[31:0] >> shamt[4:0];
    assign sraWord = $signed(a[31:0]) >>> shamt[4:0];  // Fills from bit 31.
    assign sraFull = $signed(a) >>> shamt;             // Fills from bit 63.

    always_comb begin
        case (ctrl.op)
            ADD, SUB: raw = sum;
            AND:      raw = a & b;
            OR:       raw = a | b;
            XOR:      raw = a ^ b;
            SLL:      raw = a << shamt;
            SRL:      raw = ctrl.word ? {32'b0, srlWord} : a >> shamt;
            SRA:      raw = ctrl.word ? {32'b0, sraWord} : sraFull;
            SLT:      raw = {{MSB{1'b0}}, lessSigned};
            SLTU:     raw = {{MSB{1'b0}}, lessUnsigned};
            PASSB:    raw = b;
            default:  raw = '0;
        endcase
    end

    assign result = ctrl.word ? {{(`EXU_XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

//--- rtl/pipeStage.sv
// ----------------------------------------------------------
// One-cycle pipeline register with a valid bit. The payload
// type is chosen per instance.
// ----------------------------------------------------------
`timescale 1ns/100ps

module pipeStage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     inValid,
    input  payload_t inData,
    output logic     outValid,
    output payload_t outData
);

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            outData <= inData;  // Holds while idle.
        end
    end

endmodule

//--- rtl/exuCore.sv
// ----------------------------------------------------------
// Execute subsystem top: decode, issue stage, register file,
// ALU and writeback. Results show two edges after instValid.
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "exu_config.svh"

module exuCore import exuPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        instValid,
    input  logic [31:0] inst,
    output logic        wbValid,
    output wbReq_t      wb,
    output logic        illegal
);

    issue_t               decIssue, issueQ;
    logic                 decIllegal;
    logic                 issueLoad, issueValid;
    logic [`EXU_XLEN-1:0] rdata1, rdata2;
    logic [`EXU_XLEN-1:0] operandB, aluResult;
    wbReq_t               wbReq;

    aluDecode decodeInst (.inst(inst), .dec(decIssue), .illegal(decIllegal));

    assign issueLoad = instValid && !decIllegal;

    pipeStage #(.payload_t(issue_t)) issueStage (
        .clk(clk), .reset(reset),
        .inValid(issueLoad), .inData(decIssue),
        .outValid(issueValid), .outData(issueQ)
    );

    // Write port fed back from the writeback stage.
    regFile regFileInst (
        .clk(clk), .reset(reset),
        .rs1(issueQ.rs1), .rs2(issueQ.rs2),
        .rdata1(rdata1), .rdata2(rdata2),
        .we(wbValid), .wr(wb)
    );

    assign operandB = issueQ.ctrl.useImm ? issueQ.imm : rdata2;

    alu aluInst (.a(rdata1), .b(operandB), .ctrl(issueQ.ctrl), .result(aluResult));

    assign wbReq = '{rd: issueQ.rd, data: aluResult};

    pipeStage #(.payload_t(wbReq_t)) wbStage (
        .clk(clk), .reset(reset),
        .inValid(issueValid), .inData(wbReq),
        .outValid(wbValid), .outData(wb)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            illegal <= 1'b0;
        end else begin
            illegal <= instValid && decIllegal;  // Same cycle as issue stage.
        end
    end

endmodule

//--- sim/exuCore_chk.sv
// ----------------------------------------------------------
// Protocol assertions for exuCore, attached with bind.
// ----------------------------------------------------------
`timescale 1ns/100ps

module exuCore_chk (
    input logic clk,
    input logic reset,
    input logic issueValid,
    input logic wbValid,
    input logic illegal
);

    // Writeback is the issue stage delayed by one edge.
    wbFollowsIssue: assert property (@(posedge clk)
        !reset && !$past(reset) |-> wbValid == $past(issueValid))
        else $error("wbValid does not follow issueValid by one cycle");

    noWbWithIllegal: assert property (@(posedge clk) disable iff (reset)
        !(wbValid && illegal))
        else $error("wbValid and illegal high in the same cycle");

    quietAfterReset: assert property (@(posedge clk)
        $past(reset) |-> !wbValid && !illegal)
        else $error("wbValid or illegal high right after reset");

endmodule

bind exuCore exuCore_chk chkInst (
    .clk(clk), .reset(reset), .issueValid(issueValid),
    .wbValid(wbValid), .illegal(illegal)
);

//--- sim/exuCore_tb.sv
// ----------------------------------------------------------
// Testbench for exuCore. Drives instructions from the cases
// file and checks writeback, illegal pulses and their timing.
// ----------------------------------------------------------
`timescale 1ns/100ps

module exuCore_tb import exuPkg::*; ();

    logic        clk;
    logic        reset;
    logic        instValid;
    logic [31:0] inst;
    logic        wbValid;
    wbReq_t      wb;
    logic        illegal;

    int          gapQ[$];
    logic [31:0] instQ[$];
    logic        illQ[$];
    wbReq_t      wbQ[$];
    logic        pendIll[$];
    wbReq_t      pendWb[$];
    int          pendDue[$];
    int          pendId[$];
    int          edgeCount = 0;
    int          totalGap = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    bit          loaded = 1'b0;

    exuCore exuCore_inst (
        .clk(clk), .reset(reset), .instValid(instValid), .inst(inst),
        .wbValid(wbValid), .wb(wb), .illegal(illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) edgeCount <= edgeCount + 1;

    task automatic loadCases();
        int          fd;
        int          n;
        int          gap;
        int          ill;
        int          rd;
        string       line;
        logic [31:0] word;
        logic [63:0] data;
        wbReq_t      exp;
        fd = $fopen("sim/exu_cases.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %h %d %d %h", gap, word, ill, rd, data);
                if (n == 5) begin
                    exp.rd   = rd[4:0];
                    exp.data = data;
                    gapQ.push_back(gap);
                    instQ.push_back(word);
                    illQ.push_back(ill[0]);
                    wbQ.push_back(exp);
                    totalGap += gap;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic checkWb(input int id, input wbReq_t expected, input wbReq_t actual);
        if (actual !== expected) begin
            $display("FAILED case %0d wb: expected rd %h data %h, got rd %h data %h",
                     id, expected.rd, expected.data, actual.rd, actual.data);
            valueErrors++;
        end
    endtask

    task automatic checkIllegal(input int id, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED case %0d illegal: expected %h, got %h", id, expected, actual);
            valueErrors++;
        end
    endtask

    // One expected event per output pulse, in issue order.
    always @(negedge clk) begin
        logic   expIll;
        wbReq_t expWb;
        int     due;
        int     id;
        if (!reset && (wbValid || illegal)) begin
            if (pendDue.size() == 0) begin
                $display("Output pulse at edge %0d with no instruction pending", edgeCount);
                otherErrors++;
            end else begin
                expIll = pendIll.pop_front();
                expWb  = pendWb.pop_front();
                due    = pendDue.pop_front();
                id     = pendId.pop_front();
                checkIllegal(id, expIll, illegal);
                if (!expIll) checkWb(id, expWb, wb);
                if (edgeCount != due) begin
                    $display("Case %0d answered after edge %0d instead of edge %0d",
                             id, edgeCount, due);
                    otherErrors++;
                end
            end
        end
    end

    initial begin
        int timeLimit;
        wait (loaded);
        timeLimit = (instQ.size() + totalGap + 20) * 10;
        #(timeLimit);
        $display("Run timed out after %0d ns with %0d results outstanding",
                 timeLimit, pendDue.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int sampleEdge;
        reset     = 1'b1;
        instValid = 1'b0;
        inst      = '0;
        loadCases();
        if (instQ.size() == 0) begin
            $display("No cases could be read from sim/exu_cases.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            for (int i = 0; i < instQ.size(); i++) begin
                repeat (gapQ[i]) begin
                    @(posedge clk);
                    instValid <= 1'b0;
                end
                @(posedge clk);
                instValid <= 1'b1;
                inst      <= instQ[i];
                sampleEdge = edgeCount + 2;  // DUT samples on the next edge.
                pendIll.push_back(illQ[i]);
                pendWb.push_back(wbQ[i]);
                pendDue.push_back(illQ[i] ? sampleEdge : sampleEdge + 1);
                pendId.push_back(i + 1);
            end
            @(posedge clk);
            instValid <= 1'b0;
            while (pendDue.size() != 0) @(posedge clk);
            repeat (3) @(posedge clk);  // Catch stray pulses.
            $display("Run complete: %0d value errors, %0d other errors",
                     valueErrors, otherErrors);
            if (valueErrors + otherErrors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

//--- exuCore.f
+incdir+rtl
rtl/exuPkg.sv
rtl/aluDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pipeStage.sv
rtl/exuCore.sv
sim/exuCore_chk.sv
sim/exuCore_tb.sv

//--- Makefile
# Verilator build and run for the execute subsystem testbench.

SRCS := exuCore.f $(wildcard rtl/*.sv rtl/*.svh sim/*.sv)

.PHONY: all run clean

all: run

obj_dir/VexuCore_tb: $(SRCS)
	verilator --binary --timing --assert -f exuCore.f \
		--top-module exuCore_tb -o VexuCore_tb

run: obj_dir/VexuCore_tb
	obj_dir/VexuCore_tb | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/exu_cases.txt
# Columns: idle cycles before, instruction (hex), expected illegal,
# expected rd (decimal), expected wb data (hex). Illegal rows use rd 0, data 0.
0 123450B7 0 1 0000000012345000
0 67808093 0 1 0000000012345678
0 80000137 0 2 FFFFFFFF80000000
0 FFF00193 0 3 FFFFFFFFFFFFFFFF
0 00500213 0 4 0000000000000005
0 004082B3 0 5 000000001234567D
0 40120333 0 6 FFFFFFFFEDCBA98D
0 0030F3B3 0 7 0000000012345678
0 0020E433 0 8 FFFFFFFF92345678
1 0030C4B3 0 9 FFFFFFFFEDCBA987
0 00412533 0 10 0000000000000001
0 00100593 0 11 0000000000000001
0 03F59593 0 11 8000000000000000
0 0045A6B3 0 13 0000000000000001
0 00B22733 0 14 0000000000000000
0 00B237B3 0 15 0000000000000001
0 0041B833 0 16 0000000000000000
1 02415893 0 17 000000000FFFFFFF
0 41C15913 0 18 FFFFFFFFFFFFFFF8
0 004099B3 0 19 00000002468ACF00
1 01C09A1B 0 20 FFFFFFFF80000000
0 00415ABB 0 21 0000000004000000
0 40415B3B 0 22 FFFFFFFFFC000000
0 4040DB9B 0 23 0000000001234567
0 02500C93 0 25 0000000000000025
0 01909C3B 0 24 00000000468ACF00
0 00208D3B 0 26 FFFFFFFF92345678
0 40120DBB 0 27 FFFFFFFFEDCBA98D
1 00708013 0 0 000000001234567F
0 00000E33 0 28 0000000000000000
1 0000B283 1 0 0000000000000000
0 12300E93 0 29 0000000000000123
1 022082B3 1 0 0000000000000000
0 005E8F33 0 30 00000000123457A0
